// ==== Makefile ====
TOP = tb_sincos

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100000 | tee sim.log
	grep -q "TB PASSED" sim.log

obj_dir/V$(TOP): sources.f logic/*.sv sim/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== logic/phase_fold.sv ====
// Phase folding stage producing table addresses and sign flags for sine and cosine
module phase_fold (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            ce,
	input  logic                            sclr,
	input  sincos_types_pkg::theta_t        theta,
	input  logic                            nd,
	output sincos_table_pkg::table_index_t  sin_addr,
	output sincos_table_pkg::table_index_t  cos_addr,
	output logic                            sin_neg,
	output logic                            cos_neg,
	output logic                            fold_valid
);

	import sincos_types_pkg::*;
	import sincos_table_pkg::*;

	theta_t       cos_theta;
	table_index_t sin_addr_next;
	table_index_t cos_addr_next;
	logic         sin_neg_next;
	logic         cos_neg_next;

	// Odd quadrants run the table backwards from the peak
	function automatic table_index_t fold_address(input theta_t phase);
		quadrant_t quadrant;
		offset_t   offset;
		quadrant = phase[THETA_WIDTH-1 -: QUADRANT_WIDTH];
		offset = phase[OFFSET_WIDTH-1:0];
		if (quadrant[0])
			return QUARTER_INDEX - table_index_t'(offset);
		return table_index_t'(offset);
	endfunction

	// Lower half of the turn is positive
	function automatic logic fold_sign(input theta_t phase);
		quadrant_t quadrant;
		quadrant = phase[THETA_WIDTH-1 -: QUADRANT_WIDTH];
		return quadrant[1];
	endfunction

	// cos(x) = sin(x + quarter turn), the sum wraps in the phase width
	assign cos_theta = theta + QUARTER_TURN;

	assign sin_addr_next = fold_address(theta);
	assign cos_addr_next = fold_address(cos_theta);
	assign sin_neg_next = fold_sign(theta);
	assign cos_neg_next = fold_sign(cos_theta);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fold_valid <= 1'b0;
		else if (ce)
			fold_valid <= nd && !sclr;
	end

	// Addresses only move with new data
	always_ff @(posedge clk)
	begin
		if (ce && nd)
		begin
			sin_addr <= sin_addr_next;
			cos_addr <= cos_addr_next;
			sin_neg <= sin_neg_next;
			cos_neg <= cos_neg_next;
		end
	end

endmodule

// ==== logic/quarter_wave_rom.sv ====
// Quarter-sine table with two registered read ports and sign flag pass-through
module quarter_wave_rom (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            ce,
	input  logic                            sclr,
	input  sincos_table_pkg::table_index_t  sin_addr,
	input  sincos_table_pkg::table_index_t  cos_addr,
	input  logic                            sin_neg,
	input  logic                            cos_neg,
	input  logic                            fold_valid,
	output sincos_types_pkg::amplitude_t    sin_mag,
	output sincos_types_pkg::amplitude_t    cos_mag,
	output logic                            mag_sin_neg,
	output logic                            mag_cos_neg,
	output logic                            mag_valid
);

	import sincos_types_pkg::*;
	import sincos_table_pkg::*;

	amplitude_t quarter_sine [0:TABLE_DEPTH-1];

	// Entry i is round(FULL_SCALE * sin(pi/2 * i / 256))
	function automatic amplitude_t quarter_sine_entry(input int index);
		real angle;
		real scaled;
		angle = HALF_PI * real'(index) / real'(TABLE_DEPTH - 1);
		scaled = real'(FULL_SCALE) * $sin(angle);
		// All entries are non-negative so adding a half rounds to nearest
		return amplitude_t'($rtoi(scaled + 0.5));
	endfunction

	initial
	begin
		for (int i = 0; i < TABLE_DEPTH; i++)
			quarter_sine[i] = quarter_sine_entry(i);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mag_valid <= 1'b0;
		else if (ce)
			mag_valid <= fold_valid && !sclr;
	end

	// Both lookups share the table, one read each per cycle
	always_ff @(posedge clk)
	begin
		if (ce && fold_valid)
		begin
			sin_mag <= quarter_sine[sin_addr];
			cos_mag <= quarter_sine[cos_addr];
			mag_sin_neg <= sin_neg;
			mag_cos_neg <= cos_neg;
		end
	end

endmodule

// ==== logic/sign_restore.sv ====
// Sign restore stage with output negation, optional output register and rdy
module sign_restore #(
	parameter bit NEGATE_SINE = 1'b0,
	parameter bit NEGATE_COSINE = 1'b0,
	parameter int OUTPUT_REG = 0
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          ce,
	input  logic                          sclr,
	input  sincos_types_pkg::amplitude_t  sin_mag,
	input  sincos_types_pkg::amplitude_t  cos_mag,
	input  logic                          mag_sin_neg,
	input  logic                          mag_cos_neg,
	input  logic                          mag_valid,
	output sincos_types_pkg::amplitude_t  sine,
	output sincos_types_pkg::amplitude_t  cosine,
	output logic                          rdy
);

	import sincos_types_pkg::*;

	amplitude_t signed_sin;
	amplitude_t signed_cos;
	amplitude_t stage_sine;
	amplitude_t stage_cosine;
	logic       stage_valid;

	function automatic amplitude_t apply_sign(input amplitude_t mag, input logic flip);
		return flip ? -mag : mag;
	endfunction

	// A negative quadrant and a negated output cancel out
	assign signed_sin = apply_sign(sin_mag, mag_sin_neg ^ NEGATE_SINE);
	assign signed_cos = apply_sign(cos_mag, mag_cos_neg ^ NEGATE_COSINE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stage_valid <= 1'b0;
			stage_sine <= '0;
			stage_cosine <= '0;
		end
		else if (ce)
		begin
			if (sclr)
			begin
				stage_valid <= 1'b0;
				stage_sine <= '0;
				stage_cosine <= '0;
			end
			else
			begin
				stage_valid <= mag_valid;
				// Outputs hold the last sample between items
				if (mag_valid)
				begin
					stage_sine <= signed_sin;
					stage_cosine <= signed_cos;
				end
			end
		end
	end

	generate
		if (OUTPUT_REG == 1)
		begin : g_out_reg
			always_ff @(posedge clk or negedge rst_n)
			begin
				if (!rst_n)
				begin
					rdy <= 1'b0;
					sine <= '0;
					cosine <= '0;
				end
				else if (ce)
				begin
					if (sclr)
					begin
						rdy <= 1'b0;
						sine <= '0;
						cosine <= '0;
					end
					else
					begin
						rdy <= stage_valid;
						if (stage_valid)
						begin
							sine <= stage_sine;
							cosine <= stage_cosine;
						end
					end
				end
			end
		end
		else
		begin : g_no_out_reg
			assign rdy = stage_valid;
			assign sine = stage_sine;
			assign cosine = stage_cosine;
		end
	endgenerate

endmodule

// ==== logic/sincos_lut.sv ====
// Top level of the quarter-wave sine and cosine generator
module sincos_lut #(
	parameter bit NEGATE_SINE = 1'b0,
	parameter bit NEGATE_COSINE = 1'b0,
	parameter int OUTPUT_REG = 0
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          ce,
	input  logic                          sclr,
	input  logic                          nd,
	input  sincos_types_pkg::theta_t      theta,
	output sincos_types_pkg::amplitude_t  sine,
	output sincos_types_pkg::amplitude_t  cosine,
	output logic                          rdy
);

	import sincos_types_pkg::*;
	import sincos_table_pkg::*;

	table_index_t sin_addr;
	table_index_t cos_addr;
	logic         sin_neg;
	logic         cos_neg;
	logic         fold_valid;

	amplitude_t   sin_mag;
	amplitude_t   cos_mag;
	logic         mag_sin_neg;
	logic         mag_cos_neg;
	logic         mag_valid;

	phase_fold u_phase_fold (
		.clk        (clk),
		.rst_n      (rst_n),
		.ce         (ce),
		.sclr       (sclr),
		.theta      (theta),
		.nd         (nd),
		.sin_addr   (sin_addr),
		.cos_addr   (cos_addr),
		.sin_neg    (sin_neg),
		.cos_neg    (cos_neg),
		.fold_valid (fold_valid)
	);

	quarter_wave_rom u_quarter_wave_rom (
		.clk         (clk),
		.rst_n       (rst_n),
		.ce          (ce),
		.sclr        (sclr),
		.sin_addr    (sin_addr),
		.cos_addr    (cos_addr),
		.sin_neg     (sin_neg),
		.cos_neg     (cos_neg),
		.fold_valid  (fold_valid),
		.sin_mag     (sin_mag),
		.cos_mag     (cos_mag),
		.mag_sin_neg (mag_sin_neg),
		.mag_cos_neg (mag_cos_neg),
		.mag_valid   (mag_valid)
	);

	sign_restore #(
		.NEGATE_SINE   (NEGATE_SINE),
		.NEGATE_COSINE (NEGATE_COSINE),
		.OUTPUT_REG    (OUTPUT_REG)
	) u_sign_restore (
		.clk         (clk),
		.rst_n       (rst_n),
		.ce          (ce),
		.sclr        (sclr),
		.sin_mag     (sin_mag),
		.cos_mag     (cos_mag),
		.mag_sin_neg (mag_sin_neg),
		.mag_cos_neg (mag_cos_neg),
		.mag_valid   (mag_valid),
		.sine        (sine),
		.cosine      (cosine),
		.rdy         (rdy)
	);

endmodule

// ==== logic/sincos_table_pkg.sv ====
// Quarter-wave table depth, address type, peak value and angle scale
package sincos_table_pkg;

	// Entries 0 and 256 hold the angles zero and a quarter turn exactly
	localparam int TABLE_DEPTH = 257;

	localparam int TABLE_INDEX_WIDTH = $clog2(TABLE_DEPTH);

	typedef logic [TABLE_INDEX_WIDTH-1:0] table_index_t;

	// Last table address, the peak of the quarter wave
	localparam table_index_t QUARTER_INDEX = table_index_t'(TABLE_DEPTH - 1);

	// Table peak, one count below the signed 16-bit limit
	localparam int FULL_SCALE = 32767;

	// Angle covered by the whole table, in radians
	localparam real HALF_PI = 1.5707963267948966;

endpackage

// ==== logic/sincos_types_pkg.sv ====
// Phase, quadrant, offset and amplitude types for the sine and cosine pipeline
package sincos_types_pkg;

	// 1024 phase counts make one full turn
	localparam int THETA_WIDTH = 10;

	// Top phase bits select the quadrant
	localparam int QUADRANT_WIDTH = 2;
	localparam int OFFSET_WIDTH = THETA_WIDTH - QUADRANT_WIDTH;

	// Signed output samples
	localparam int AMPLITUDE_WIDTH = 16;

	typedef logic [THETA_WIDTH-1:0] theta_t;

	typedef logic [QUADRANT_WIDTH-1:0] quadrant_t;

	typedef logic [OFFSET_WIDTH-1:0] offset_t;

	typedef logic signed [AMPLITUDE_WIDTH-1:0] amplitude_t;

	// Phase step of 90 degrees, cosine leads sine by this much
	localparam theta_t QUARTER_TURN = theta_t'(1) << OFFSET_WIDTH;

endpackage

// ==== sim/sincos_assertions.sv ====
// Bound checker for rdy latency, output values, stall hold, clear and idle outputs
module sincos_assertions #(
	parameter bit NEGATE_SINE = 1'b0,
	parameter bit NEGATE_COSINE = 1'b0
) (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          ce,
	input logic                          sclr,
	input logic                          nd,
	input sincos_types_pkg::theta_t      theta,
	input sincos_types_pkg::amplitude_t  sine,
	input sincos_types_pkg::amplitude_t  cosine,
	input logic                          rdy
);
	timeunit 1ns;
	timeprecision 1ps;

	import sincos_types_pkg::*;

	localparam real TWO_PI = 6.283185307179586;
	localparam real PHASE_COUNTS = 1024.0;
	localparam real PEAK = 32767.0;

	int           fail_count = 0;
	logic [3:0]   valid_sh;
	theta_t [3:0] theta_sh;
	logic         loaded;
	int           sine_expect;
	int           cosine_expect;

	function automatic int round_to_int(input real value);
		if (value < 0.0)
			return -$rtoi(0.5 - value);
		return $rtoi(value + 0.5);
	endfunction

	function automatic bit value_close(input int actual, input int expected);
		return (actual - expected <= 1) && (expected - actual <= 1);
	endfunction

	// Last 4 enabled cycles of nd and theta, cleared together with the pipeline
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_sh <= '0;
			theta_sh <= '0;
		end
		else if (ce)
		begin
			valid_sh <= sclr ? 4'b0000 : {valid_sh[2:0], nd};
			theta_sh <= {theta_sh[2:0], theta};
		end
	end

	// Set once a result has reached the outputs
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			loaded <= 1'b0;
		else if (ce && sclr)
			loaded <= 1'b0;
		else if (rdy)
			loaded <= 1'b1;
	end

	always_comb
	begin
		sine_expect = round_to_int(PEAK * $sin(TWO_PI * real'(theta_sh[3]) / PHASE_COUNTS));
		cosine_expect = round_to_int(PEAK * $cos(TWO_PI * real'(theta_sh[3]) / PHASE_COUNTS));
		if (NEGATE_SINE)
			sine_expect = -sine_expect;
		if (NEGATE_COSINE)
			cosine_expect = -cosine_expect;
	end

	a_rdy_latency: assert property (@(posedge clk) disable iff (!rst_n) rdy == valid_sh[3])
	else
	begin
		fail_count++;
		$error("Error at %0t: rdy = %b, expected %b", $time, $sampled(rdy),
			$sampled(valid_sh[3]));
	end

	a_sine_value: assert property (@(posedge clk) disable iff (!rst_n)
		rdy |-> value_close(sine, sine_expect))
	else
	begin
		fail_count++;
		$error("Error at %0t: sine = %0d, expected %0d", $time, $sampled(sine),
			$sampled(sine_expect));
	end

	a_cosine_value: assert property (@(posedge clk) disable iff (!rst_n)
		rdy |-> value_close(cosine, cosine_expect))
	else
	begin
		fail_count++;
		$error("Error at %0t: cosine = %0d, expected %0d", $time, $sampled(cosine),
			$sampled(cosine_expect));
	end

	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!ce |=> $stable(rdy) && $stable(sine) && $stable(cosine))
	else
	begin
		fail_count++;
		$error("Outputs changed at %0t although ce was low", $time);
	end

	a_clear: assert property (@(posedge clk) disable iff (!rst_n)
		ce && sclr |=> !rdy && sine == '0 && cosine == '0)
	else
	begin
		fail_count++;
		$error("Outputs not cleared at %0t after sclr with ce high", $time);
	end

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!loaded && !rdy |-> sine == '0 && cosine == '0)
	else
	begin
		fail_count++;
		$error("Outputs not zero at %0t before the first result", $time);
	end

endmodule

// ==== sim/tb_sincos.sv ====
// Testbench for the sine and cosine generator with clock, reset, stimulus and verdict
module tb_sincos;
	timeunit 1ns;
	timeprecision 1ps;

	import sincos_types_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_TIMEOUT = 64;

	logic        clk;
	logic        rst_n;
	logic        ce;
	logic        sclr;
	logic        nd;
	theta_t      theta;
	amplitude_t  sine;
	amplitude_t  cosine;
	logic        rdy;

	int unsigned lcg_state;
	int          pending;
	int          timeout_count;
	int          test_count;
	int          fails_before;

	sincos_lut #(
		.NEGATE_SINE   (1'b0),
		.NEGATE_COSINE (1'b1),
		.OUTPUT_REG    (1)
	) UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.ce     (ce),
		.sclr   (sclr),
		.nd     (nd),
		.theta  (theta),
		.sine   (sine),
		.cosine (cosine),
		.rdy    (rdy)
	);

	bind sincos_lut sincos_assertions #(
		.NEGATE_SINE   (NEGATE_SINE),
		.NEGATE_COSINE (NEGATE_COSINE)
	) u_assertions (
		.clk    (clk),
		.rst_n  (rst_n),
		.ce     (ce),
		.sclr   (sclr),
		.nd     (nd),
		.theta  (theta),
		.sine   (sine),
		.cosine (cosine),
		.rdy    (rdy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Phases accepted but not yet delivered on rdy
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pending <= 0;
		else if (ce)
			pending <= sclr ? 0 : pending + int'(nd) - int'(rdy);
	end

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	function automatic int total_failures();
		return UUT.u_assertions.fail_count + timeout_count;
	endfunction

	task automatic report_test(input string name);
		int fails_now;
		fails_now = total_failures();
		test_count++;
		$display("Test %0d %s: %0d failures", test_count, name, fails_now - fails_before);
		fails_before = fails_now;
	endtask

	task automatic drive_phase(input logic enable, input logic new_data, input theta_t phase);
		@(negedge clk);
		ce = enable;
		nd = new_data;
		theta = phase;
	endtask

	task automatic drain_pipeline(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		ce = 1'b1;
		nd = 1'b0;
		sclr = 1'b0;
		while (pending != 0 && cycles < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (pending != 0)
		begin
			$display("%s: timed out waiting for rdy, %0d phases still missing", name, pending);
			timeout_count++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		ce = 1'b0;
		sclr = 1'b0;
		nd = 1'b0;
		theta = '0;
		lcg_state = 15;
		timeout_count = 0;
		test_count = 0;
		fails_before = 0;

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		ce = 1'b1;
		repeat (12) @(negedge clk);
		report_test("reset idle");

		// Quadrant boundaries first, then every phase
		for (int b = 0; b < 4; b++)
			drive_phase(1'b1, 1'b1, theta_t'(b * 256));
		for (int p = 0; p < 1024; p++)
			drive_phase(1'b1, 1'b1, theta_t'(p));
		drain_pipeline("sweep");
		report_test("sweep");

		for (int i = 0; i < 400; i++)
			drive_phase(1'b1, (next_random() % 3) != 0, theta_t'(next_random()));
		drain_pipeline("random nd");
		report_test("random nd");

		for (int i = 0; i < 400; i++)
			drive_phase((next_random() % 4) != 0, (next_random() % 2) != 0,
				theta_t'(next_random()));
		drain_pipeline("ce stalls");
		report_test("ce stalls");

		for (int round = 0; round < 8; round++)
		begin
			for (int i = 0; i < 3 + int'(next_random() % 6); i++)
				drive_phase(1'b1, 1'b1, theta_t'(next_random()));
			// sclr is ignored while ce is low
			drive_phase(1'b0, 1'b1, theta_t'(next_random()));
			sclr = 1'b1;
			drive_phase(1'b1, 1'b1, theta_t'(next_random()));
			drive_phase(1'b1, 1'b0, theta);
			sclr = 1'b0;
			repeat (6) @(negedge clk);
			drain_pipeline("sclr");
		end
		report_test("sclr");

		$display("Tests run: %0d, assertion failures: %0d, timeouts: %0d", test_count,
			UUT.u_assertions.fail_count, timeout_count);
		if (total_failures() == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
logic/sincos_types_pkg.sv
logic/sincos_table_pkg.sv
logic/phase_fold.sv
logic/quarter_wave_rom.sv
logic/sign_restore.sv
logic/sincos_lut.sv
sim/sincos_assertions.sv
sim/tb_sincos.sv
